/* logic/scan_pkg.sv */
`default_nettype none

package scan_pkg;

  // Rule and stream dimensions
  localparam int NUM_RULES   = 2;
  localparam int STREAM_ID_W = 6;
  localparam int NUM_STREAMS = 64;

  // Fixed pattern length in bytes
  localparam int PATTERN_LEN = 6;

  // Last byte pulse to end of packet pulse
  // Input register plus DFA plus accept register
  localparam int DRAIN_CYCLES = 3;

  // Load pulse to first byte pulse
  // Memory read plus state input register
  localparam int LOAD_TO_CHAR = 3;

  // One beat of the input port
  typedef struct packed {
    logic                   sop;
    logic                   eop;
    logic [STREAM_ID_W-1:0] stream_id;
    logic [NUM_RULES-1:0]   rule_en;
    logic [7:0]             char;
  } beat_t;

  // Number of pattern bytes matched so far
  typedef logic [3:0] dfa_state_t;

  typedef logic [15:0] count_t;
  typedef count_t [NUM_RULES-1:0] rule_counts_t;

  // Gap counter used by the sequencer
  typedef logic [2:0] gap_t;
  localparam gap_t LOAD_GAP = gap_t'(LOAD_TO_CHAR - 1);
  // The byte state already spends one cycle of the drain
  localparam gap_t DRAIN_GAP = gap_t'(DRAIN_CYCLES - 2);

  // Pattern strings with rule 0 in the low slot
  typedef logic [PATTERN_LEN*8-1:0] pattern_t;
  typedef pattern_t [NUM_RULES-1:0] pattern_set_t;
  localparam pattern_set_t PATTERNS = {"telnet", "rlogin"};

  // KMP failure links indexed by matched length
  typedef dfa_state_t [PATTERN_LEN:0] fail_row_t;
  typedef fail_row_t [NUM_RULES-1:0] fail_table_t;

  // Byte idx of a pattern counted from the first character
  function automatic logic [7:0] pattern_byte(int rule, int idx);
    return PATTERNS[rule][(PATTERN_LEN - 1 - idx) * 8 +: 8];
  endfunction

  // Classic prefix function for every rule
  function automatic fail_table_t build_fail_table();
    fail_table_t tbl;
    int          r;
    int          q;
    int          k;
    tbl = '0;
    for (r = 0; r < NUM_RULES; r++)
    begin
      for (q = 1; q < PATTERN_LEN; q++)
      begin
        k = int'(tbl[r][q]);
        // Shrink the border until the next byte extends it
        while (k > 0 && pattern_byte(r, q) != pattern_byte(r, k))
          k = int'(tbl[r][k]);
        if (pattern_byte(r, q) == pattern_byte(r, k))
          k++;
        tbl[r][q + 1] = dfa_state_t'(k);
      end
    end
    return tbl;
  endfunction

  localparam fail_table_t FAIL_TABLE = build_fail_table();

endpackage

`default_nettype wire

/* logic/pattern_dfa.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_dfa #(
  parameter int RULE_IDX = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           char,
  input  logic                 char_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic                 state_in_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic                 accept_out
);

  // Current match length
  scan_pkg::dfa_state_t state_q;
  // Length after the incoming byte before fall back
  scan_pkg::dfa_state_t next_state;
  logic                 full_match;

  assign state_out  = state_q;
  assign full_match = (next_state == scan_pkg::dfa_state_t'(scan_pkg::PATTERN_LEN));

  // KMP transition
  // Walk failure links until the byte extends a prefix or we hit zero
  always_comb
  begin : kmp_step
    scan_pkg::dfa_state_t walk;
    logic                 done;
    walk       = state_q;
    done       = 1'b0;
    next_state = '0;
    for (int i = 0; i <= scan_pkg::PATTERN_LEN; i++)
    begin
      if (!done)
      begin
        if (char == scan_pkg::pattern_byte(RULE_IDX, int'(walk)))
        begin
          // Byte extends the current prefix
          next_state = walk + 1'b1;
          done       = 1'b1;
        end
        else if (walk == '0)
        begin
          // Nothing left to fall back to
          done = 1'b1;
        end
        else
        begin
          walk = scan_pkg::FAIL_TABLE[RULE_IDX][walk];
        end
      end
    end
  end

  // State register and registered accept
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= '0;
      accept_out <= 1'b0;
    end
    else
    begin
      accept_out <= 1'b0;
      // Restore from outside takes priority
      if (state_in_vld)
        state_q <= state_in;
      else if (char_vld)
      begin
        accept_out <= full_match;
        // Full match falls back so overlapping matches continue
        if (full_match)
          state_q <= scan_pkg::FAIL_TABLE[RULE_IDX][scan_pkg::PATTERN_LEN];
        else
          state_q <= next_state;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/stream_rule_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_rule_unit #(
  parameter int RULE_IDX = 0
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             load_state,
  input  logic                             is_new,
  input  logic [scan_pkg::STREAM_ID_W-1:0] stream_id,
  input  logic                             enable,
  input  logic [7:0]                       char,
  input  logic                             char_vld,
  input  logic                             eop,
  output scan_pkg::count_t                 count,
  output logic                             fired
);

  // Saved DFA state per stream
  scan_pkg::dfa_state_t state_mem [scan_pkg::NUM_STREAMS];

  // Restored state
  scan_pkg::dfa_state_t state_in;
  logic                 state_in_vld;

  // DFA input registers
  logic [7:0]           char_r;
  logic                 char_vld_r;
  scan_pkg::dfa_state_t state_in_r;
  logic                 state_in_vld_r;

  // DFA outputs and their registers
  scan_pkg::dfa_state_t state_out;
  logic                 accept_out;
  scan_pkg::dfa_state_t state_out_r;
  logic                 accept_r;

  // Packet has matched so far
  logic spec_match;
  // Includes an accept that lands on the eop cycle
  logic pkt_hit;

  assign fired   = spec_match;
  assign pkt_hit = spec_match | accept_r;

  // Restore one cycle after load
  // New stream starts empty
  always_ff @(posedge clk)
  begin
    if (load_state)
    begin
      if (is_new)
        state_in <= '0;
      else
        state_in <= state_mem[stream_id];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= load_state;
  end

  // Memory write port
  // Fresh stream gets an empty entry so later restores read a clean state
  always_ff @(posedge clk)
  begin
    if (load_state && is_new)
      state_mem[stream_id] <= '0;
    else if (eop && enable)
      state_mem[stream_id] <= state_out_r;
  end

  // Data side of the DFA registers
  always_ff @(posedge clk)
  begin
    char_r      <= char;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Valid side of the DFA registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r     <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      char_vld_r     <= char_vld;
      state_in_vld_r <= state_in_vld;
      accept_r       <= accept_out;
    end
  end

  // Match flag and packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      spec_match <= 1'b0;
    end
    else
    begin
      // New packet starts without a match
      if (load_state)
        spec_match <= 1'b0;
      if (accept_r)
        spec_match <= 1'b1;
      // Close out the packet
      if (eop)
      begin
        if (enable)
          count <= count + scan_pkg::count_t'(pkt_hit);
        else
          spec_match <= 1'b0;
      end
    end
  end

  pattern_dfa #(
    .RULE_IDX(RULE_IDX)
  ) dfa_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .char        (char_r),
    .char_vld    (char_vld_r),
    .state_in    (state_in_r),
    .state_in_vld(state_in_vld_r),
    .state_out   (state_out),
    .accept_out  (accept_out)
  );

endmodule

`default_nettype wire

/* logic/stream_table.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_table (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             lookup,
  input  logic [scan_pkg::STREAM_ID_W-1:0] stream_id,
  output logic                             is_new
);

  // One bit per stream id
  // Set once the stream has been looked up
  logic [scan_pkg::NUM_STREAMS-1:0] seen;

  // Same cycle answer for the id on the bus
  assign is_new = ~seen[stream_id];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      seen <= '0;
    else if (lookup)
      seen[stream_id] <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/beat_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_sequencer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  scan_pkg::beat_t                  beat,
  input  logic                             req,
  output logic                             ack,
  output logic                             load_state,
  output logic                             char_vld,
  output logic                             eop,
  output logic [scan_pkg::STREAM_ID_W-1:0] stream_id,
  output logic [scan_pkg::NUM_RULES-1:0]   rule_en,
  output logic [7:0]                       char
);

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LOAD_WAIT,
    SEQ_BYTE,
    SEQ_DRAIN,
    SEQ_ACK
  } seq_state_t;

  seq_state_t     state_q;
  scan_pkg::gap_t gap_cnt;

  // Captured byte and end flag of the current beat
  logic [7:0] char_q;
  logic       last_q;

  assign char = char_q;

  // Payload capture on handshake start
  always_ff @(posedge clk)
  begin
    if (state_q == SEQ_IDLE && req)
    begin
      char_q <= beat.char;
      last_q <= beat.eop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= SEQ_IDLE;
      gap_cnt    <= '0;
      ack        <= 1'b0;
      load_state <= 1'b0;
      char_vld   <= 1'b0;
      eop        <= 1'b0;
      stream_id  <= '0;
      rule_en    <= '0;
    end
    else
    begin
      // Pulses last one cycle
      load_state <= 1'b0;
      char_vld   <= 1'b0;
      eop        <= 1'b0;
      case (state_q)
        SEQ_IDLE:
        begin
          if (req)
          begin
            if (beat.sop)
            begin
              // Packet context held until the next sop
              stream_id  <= beat.stream_id;
              rule_en    <= beat.rule_en;
              load_state <= 1'b1;
              gap_cnt    <= scan_pkg::LOAD_GAP;
              state_q    <= SEQ_LOAD_WAIT;
            end
            else
            begin
              char_vld <= 1'b1;
              state_q  <= SEQ_BYTE;
            end
          end
        end
        SEQ_LOAD_WAIT:
        begin
          // Give the rule units time to restore state
          if (gap_cnt == '0)
          begin
            char_vld <= 1'b1;
            state_q  <= SEQ_BYTE;
          end
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        SEQ_BYTE:
        begin
          // char_vld is high in this cycle
          if (last_q)
          begin
            gap_cnt <= scan_pkg::DRAIN_GAP;
            state_q <= SEQ_DRAIN;
          end
          else
          begin
            ack     <= 1'b1;
            state_q <= SEQ_ACK;
          end
        end
        SEQ_DRAIN:
        begin
          // Let the last byte clear the DFA pipeline before eop
          if (eop)
          begin
            ack     <= 1'b1;
            state_q <= SEQ_ACK;
          end
          else if (gap_cnt == '0)
            eop <= 1'b1;
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        SEQ_ACK:
        begin
          // Stall here until the source drops req
          if (!req)
          begin
            ack     <= 1'b0;
            state_q <= SEQ_IDLE;
          end
        end
        default:
          state_q <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/pattern_scan_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_scan_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  scan_pkg::beat_t                beat,
  input  logic                           req,
  output logic                           ack,
  output scan_pkg::rule_counts_t         counts,
  output logic [scan_pkg::NUM_RULES-1:0] fired
);

  // Sequencer to rule units
  logic                             load_state;
  logic                             char_vld;
  logic                             eop;
  logic [scan_pkg::STREAM_ID_W-1:0] stream_id;
  logic [scan_pkg::NUM_RULES-1:0]   rule_en;
  logic [7:0]                       char;

  // Stream table answer for the load cycle
  logic is_new;

  beat_sequencer seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .beat      (beat),
    .req       (req),
    .ack       (ack),
    .load_state(load_state),
    .char_vld  (char_vld),
    .eop       (eop),
    .stream_id (stream_id),
    .rule_en   (rule_en),
    .char      (char)
  );

  // Lookup happens on the load pulse
  stream_table table_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .lookup   (load_state),
    .stream_id(stream_id),
    .is_new   (is_new)
  );

  // One rule unit per pattern
  for (genvar r = 0; r < scan_pkg::NUM_RULES; r++)
  begin : g_rule
    stream_rule_unit #(
      .RULE_IDX(r)
    ) rule_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .load_state(load_state),
      .is_new    (is_new),
      .stream_id (stream_id),
      .enable    (rule_en[r]),
      .char      (char),
      .char_vld  (char_vld),
      .eop       (eop),
      .count     (counts[r]),
      .fired     (fired[r])
    );
  end

endmodule

`default_nettype wire

/* tests/pattern_scan_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_scan_assertions (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           req,
  input logic                           ack,
  input scan_pkg::rule_counts_t         counts,
  input logic [scan_pkg::NUM_RULES-1:0] fired
);

  // Failed assertions so far, read by the testbench at the end
  int fail_cnt = 0;

  // ack only answers a pending req
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
  else
  begin
    fail_cnt++;
    $error("ack rose while req was low");
  end

  // Source keeps req up until ack arrives
  req_held: assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |-> ack)
  else
  begin
    fail_cnt++;
    $error("req dropped before ack rose");
  end

  // New request only once the last ack is gone
  req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |-> !ack)
  else
  begin
    fail_cnt++;
    $error("req raised again while ack was still high");
  end

  // ack falls only after req is released
  ack_falls_late: assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !req)
  else
  begin
    fail_cnt++;
    $error("ack fell while req was still high");
  end

  // Synchronous reset clears counts, flags and ack
  reset_clears: assert property (@(posedge clk) !rst_n |=> (counts == '0 && fired == '0 && !ack))
  else
  begin
    fail_cnt++;
    $error("outputs not cleared one cycle after reset");
  end

  // Packet counts only ever grow
  for (genvar r = 0; r < scan_pkg::NUM_RULES; r++)
  begin : g_mono
    count_mono: assert property (@(posedge clk) disable iff (!rst_n)
      counts[r] >= $past(counts[r]))
    else
    begin
      fail_cnt++;
      $error("count of rule %0d decreased", r);
    end
  end

endmodule

bind pattern_scan_top pattern_scan_assertions assert_i (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .ack   (ack),
  .counts(counts),
  .fired (fired)
);

`default_nettype wire

/* tests/pattern_scan_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pattern_scan_tb;

  // Cycles allowed for each edge of ack
  localparam int ACK_TIMEOUT = 64;

  logic                           clk;
  logic                           rst_n;
  scan_pkg::beat_t                beat;
  logic                           req;
  logic                           ack;
  scan_pkg::rule_counts_t         counts;
  logic [scan_pkg::NUM_RULES-1:0] fired;

  // Pattern text per rule
  string patterns [scan_pkg::NUM_RULES] = '{"rlogin", "telnet"};

  // Reference model
  // Matched length per stream and rule, kept only on enabled eop
  bit          seen_m [scan_pkg::NUM_STREAMS];
  int          saved_len [scan_pkg::NUM_STREAMS][scan_pkg::NUM_RULES];
  logic [15:0] exp_count [scan_pkg::NUM_RULES];
  logic        exp_fired [scan_pkg::NUM_RULES];

  logic [7:0]  payload [$];
  logic [31:0] rng;
  int          errors;
  int          err_mark;
  int          test_num;
  int          tests_failed;
  bit          timed_out;

  pattern_scan_top dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .beat  (beat),
    .req   (req),
    .ack   (ack),
    .counts(counts),
    .fired (fired)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Longest pattern prefix that ends the text, at most max_k bytes
  function automatic int overlap(input int r, input logic [7:0] text [scan_pkg::PATTERN_LEN + 1],
                                 input int len, input int max_k);
    int k;
    int i;
    int found;
    bit ok;
    found = 0;
    for (k = 1; k <= max_k; k++)
    begin
      ok = 1'b1;
      for (i = 0; i < k; i++)
        if (text[len - k + i] != patterns[r][i])
          ok = 1'b0;
      if (ok)
        found = k;
    end
    return found;
  endfunction

  // Matched length after one more byte
  function automatic int next_len(input int r, input int st, input logic [7:0] c, output bit hit);
    logic [7:0] text [scan_pkg::PATTERN_LEN + 1];
    int         i;
    int         k;
    for (i = 0; i < st; i++)
      text[i] = patterns[r][i];
    text[st] = c;
    k = overlap(r, text, st + 1, st + 1);
    hit = (k == scan_pkg::PATTERN_LEN);
    // Full match resumes from the longest proper border
    if (hit)
      k = overlap(r, text, scan_pkg::PATTERN_LEN, scan_pkg::PATTERN_LEN - 1);
    return k;
  endfunction

  task automatic random_payload(input int n);
    payload.delete();
    repeat (n)
    begin
      rng = xorshift(rng);
      payload.push_back(rng[7:0]);
    end
  endtask

  task automatic splice(input string s, input int off);
    int i;
    for (i = 0; i < s.len(); i++)
      payload[off + i] = s[i];
  endtask

  // One four phase handshake
  task automatic drive_beat(input scan_pkg::beat_t b);
    int waited;
    if (timed_out)
      return;
    @(posedge clk);
    beat <= b;
    req  <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end while (!ack && waited < ACK_TIMEOUT);
    if (!ack)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: ack did not rise within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
      return;
    end
    req <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end while (ack && waited < ACK_TIMEOUT);
    if (ack)
    begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: ack did not fall within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
    end
  endtask

  task automatic check_outputs();
    int r;
    for (r = 0; r < scan_pkg::NUM_RULES; r++)
    begin
      if (counts[r] !== exp_count[r])
      begin
        errors++;
        $display("** Error at %0t ns: counts[%0d] = %0d, expected %0d",
                 $time, r, counts[r], exp_count[r]);
      end
      if (fired[r] !== exp_fired[r])
      begin
        errors++;
        $display("** Error at %0t ns: fired[%0d] = %b, expected %b",
                 $time, r, fired[r], exp_fired[r]);
      end
    end
  endtask

  // Sends the payload as one packet and steps the model alongside
  task automatic send_packet(input logic [5:0] sid, input logic [1:0] en);
    scan_pkg::beat_t b;
    int              st [scan_pkg::NUM_RULES];
    bit              hit [scan_pkg::NUM_RULES];
    bit              h;
    int              i;
    int              r;
    for (r = 0; r < scan_pkg::NUM_RULES; r++)
    begin
      // Unseen stream starts empty
      st[r]  = seen_m[sid] ? saved_len[sid][r] : 0;
      hit[r] = 1'b0;
    end
    seen_m[sid] = 1'b1;
    for (i = 0; i < payload.size(); i++)
    begin
      b.sop       = (i == 0);
      b.eop       = (i == payload.size() - 1);
      b.stream_id = sid;
      b.rule_en   = en;
      b.char      = payload[i];
      drive_beat(b);
      for (r = 0; r < scan_pkg::NUM_RULES; r++)
      begin
        st[r] = next_len(r, st[r], payload[i], h);
        if (h)
          hit[r] = 1'b1;
      end
    end
    for (r = 0; r < scan_pkg::NUM_RULES; r++)
    begin
      if (en[r])
      begin
        saved_len[sid][r] = st[r];
        if (hit[r])
          exp_count[r] = exp_count[r] + 16'd1;
        exp_fired[r] = hit[r];
      end
      else
        exp_fired[r] = 1'b0;
    end
    check_outputs();
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (errors == err_mark)
      $display("Test %0d %s: ok", test_num, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", test_num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial
  begin : main
    int          p;
    int          len;
    logic [5:0]  sid;
    logic [1:0]  en;
    int          total;
    rst_n        = 1'b0;
    req          = 1'b0;
    beat         = '0;
    rng          = 32'h3209;
    errors       = 0;
    err_mark     = 0;
    test_num     = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    exp_count    = '{default: 16'd0};
    exp_fired    = '{default: 1'b0};
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Idle outputs after reset
    if (ack !== 1'b0)
    begin
      errors++;
      $display("** Error at %0t ns: ack = %b, expected 0", $time, ack);
    end
    check_outputs();
    finish_test("reset values");

    // Whole match inside one packet
    random_payload(12);
    splice("rlogin", 3);
    send_packet(6'd1, 2'b11);
    finish_test("rlogin on new stream");

    // Split match continues on the same stream only
    random_payload(10);
    splice("tel", 7);
    send_packet(6'd2, 2'b11);
    // Second half fills the packet so the accept lands on the eop cycle
    random_payload(3);
    splice("net", 0);
    send_packet(6'd2, 2'b11);
    random_payload(10);
    splice("tel", 7);
    send_packet(6'd3, 2'b11);
    random_payload(8);
    splice("net", 0);
    send_packet(6'd1, 2'b11);
    finish_test("split across packets");

    // Disabled packets neither count nor save
    random_payload(9);
    splice("tel", 6);
    send_packet(6'd5, 2'b11);
    random_payload(10);
    splice("telnet", 2);
    send_packet(6'd5, 2'b01);
    random_payload(10);
    splice("rlogin", 1);
    send_packet(6'd5, 2'b10);
    random_payload(7);
    splice("net", 0);
    send_packet(6'd5, 2'b11);
    finish_test("disabled rule");

    // Fresh stream ignores partial matches of others
    random_payload(9);
    splice("rlog", 5);
    send_packet(6'd7, 2'b11);
    random_payload(8);
    splice("in", 0);
    send_packet(6'd8, 2'b11);
    random_payload(8);
    splice("net", 0);
    send_packet(6'd9, 2'b11);
    finish_test("fresh stream");

    // Random traffic over a few streams, single byte packets too
    for (p = 0; p < 12; p++)
    begin
      rng = xorshift(rng);
      len = 1 + int'(rng[3:0]) % 12;
      sid = 6'(10 + int'(rng[10:8]));
      en  = rng[13:12];
      random_payload(len);
      if (rng[16] && len >= scan_pkg::PATTERN_LEN)
        splice(patterns[rng[17]], int'(rng[22:20]) % (len - scan_pkg::PATTERN_LEN + 1));
      send_packet(sid, en);
    end
    finish_test("random traffic");

    total = errors + dut_i.assert_i.fail_cnt;
    $display("Tests: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             test_num, tests_failed, errors, dut_i.assert_i.fail_cnt);
    if (total == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
logic/scan_pkg.sv
logic/pattern_dfa.sv
logic/stream_rule_unit.sv
logic/stream_table.sv
logic/beat_sequencer.sv
logic/pattern_scan_top.sv
tests/pattern_scan_assertions.sv
tests/pattern_scan_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pattern scan testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pattern_scan_tb -f flist.f -o pattern_scan_sim
./obj_dir/pattern_scan_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
